// File: common/misc_pkg.sv
/* Shared widths, word types and bit positions for the misc-control block.
   Pending and enable bits follow the INT_* positions; refresh count saturates at 8. */
package misc_pkg;

	// Register and read-bus word
	localparam int unsigned DATA_W = 16;
	typedef logic [DATA_W-1:0] data_word_t;

	// One bit per interrupt source
	localparam int unsigned INT_SRC_N = 5;
	typedef logic [INT_SRC_N-1:0] int_mask_t;

	// Interrupt bit positions, same in enable mask, ack field and pending bits
	localparam int unsigned INT_VIDEO  = 0;
	localparam int unsigned INT_GPU    = 1;
	localparam int unsigned INT_OBJECT = 2;
	localparam int unsigned INT_TIMER  = 3;
	localparam int unsigned INT_DSP    = 4;

	// Acknowledge field sits in din[12:8]
	localparam int unsigned INT_ACK_LSB = 8;

	// Owed refresh count, top bit flags the full state
	localparam int unsigned REF_CNT_W = 4;
	localparam int unsigned REF_FULL_BIT = REF_CNT_W - 1;
	typedef logic [REF_CNT_W-1:0] refresh_count_t;

	// Refresh divider value, zero turns refresh off
	localparam int unsigned REF_RATE_W = 4;
	typedef logic [REF_RATE_W-1:0] refresh_rate_t;

	// Refresh bus request states
	typedef enum logic {
		REF_IDLE,
		REF_REQUEST
	} ref_state_t;

endpackage

// File: timer/pit_timer.sv
/* Prescaler and timer down-counters; a zero prescale reload stops both and keeps tint low.
   tint is a one-cycle pulse every (P+1)(T+1) cycles. */
`timescale 1ns/100ps

module pit_timer (
	input  logic                 sys_clk,
	input  logic                 resetl,
	input  misc_pkg::data_word_t din,
	input  logic                 pit0_wr,
	input  logic                 pit1_wr,
	output logic                 tint,
	output misc_pkg::data_word_t pit0_data,
	output misc_pkg::data_word_t pit1_data
);

	// Reload values written by the CPU
	misc_pkg::data_word_t pre_reload;
	misc_pkg::data_word_t tim_reload;

	// Running counters
	misc_pkg::data_word_t pre_cnt;
	misc_pkg::data_word_t tim_cnt;

	logic ten;
	logic pre_zero;
	logic tim_zero;
	logic tick;

	// Timer runs only while the prescale reload is nonzero
	assign ten = |pre_reload;

	assign pre_zero = (pre_cnt == '0);
	assign tim_zero = (tim_cnt == '0);

	// Prescaler terminal count, one per P+1 cycles
	assign tick = ten & pre_zero;

	// Terminal count of the second stage
	assign tint = tick & tim_zero;

	// Reload registers
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			pre_reload <= '0;
			tim_reload <= '0;
		end else begin
			if (pit0_wr) begin
				pre_reload <= din;
			end
			if (pit1_wr) begin
				tim_reload <= din;
			end
		end
	end

	// Prescaler
	// A write loads the counter directly, same edge as the reload
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			pre_cnt <= '0;
		end else if (pit0_wr) begin
			pre_cnt <= din;
		end else if (!ten) begin
			pre_cnt <= '0;
		end else if (pre_zero) begin
			pre_cnt <= pre_reload;
		end else begin
			pre_cnt <= pre_cnt - 1'b1;
		end
	end

	// Timer counter
	// Held at zero while disabled, even across a pit1 write
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			tim_cnt <= '0;
		end else if (!ten) begin
			tim_cnt <= '0;
		end else if (pit1_wr) begin
			tim_cnt <= din;
		end else if (tick) begin
			// Wrap back to T on the tick that fires tint
			if (tim_zero) begin
				tim_cnt <= tim_reload;
			end else begin
				tim_cnt <= tim_cnt - 1'b1;
			end
		end
	end

	// Live counter values for read-back
	assign pit0_data = pre_cnt;
	assign pit1_data = tim_cnt;

endmodule

// File: refresh/refresh_ctrl.sv
/* DRAM refresh scheduler; owed count saturates at 8 and increments while full are dropped.
   A completion needs refback, ack and mreq_in high in the same cycle. */
`timescale 1ns/100ps

module refresh_ctrl #(
	parameter int unsigned PRESCALE_BITS = 6
) (
	input  logic                     sys_clk,
	input  logic                     resetl,
	input  misc_pkg::refresh_rate_t  refresh_rate,
	input  logic                     tcount,
	input  logic                     start_ref,
	input  logic                     refback,
	input  logic                     ack,
	input  logic                     mreq_in,
	output logic                     refreq,
	output misc_pkg::refresh_count_t ref_count
);

	// Free-running prescaler
	logic [PRESCALE_BITS-1:0] ps;
	logic                     pen;

	// Rate divider
	misc_pkg::refresh_rate_t rp;
	logic                    rpcen;
	logic                    lrpc;
	logic                    rate_on;

	// Owed count control
	misc_pkg::refresh_count_t rc;
	logic                     add_ref;
	logic                     done_ref;
	logic                     full;
	logic                     notempty;

	misc_pkg::ref_state_t state;
	misc_pkg::ref_state_t state_nxt;

	// Prescaler wraps every 2^PRESCALE_BITS cycles
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			ps <= '0;
		end else begin
			ps <= ps + 1'b1;
		end
	end

	assign pen = &ps;

	// Test mode steps the divider every cycle
	assign rpcen = pen | tcount;

	// Divider passes zero, time for another refresh
	assign lrpc = rpcen & (rp == '0);

	assign rate_on = |refresh_rate;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			rp <= '0;
		end else if (lrpc) begin
			rp <= refresh_rate;
		end else if (rpcen) begin
			rp <= rp - 1'b1;
		end
	end

	assign full     = rc[misc_pkg::REF_FULL_BIT];
	assign notempty = |rc;

	// New refresh owed, only when the rate is nonzero
	assign add_ref = lrpc & rate_on;

	// Memory side finished one refresh cycle
	assign done_ref = refback & ack & mreq_in;

	// Up/down count, simultaneous add and done cancel out
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			rc <= '0;
		end else if (add_ref && !done_ref) begin
			// Saturate at the full value
			if (!full) begin
				rc <= rc + 1'b1;
			end
		end else if (done_ref && !add_ref && notempty) begin
			rc <= rc - 1'b1;
		end
	end

	// Request state machine
	always_comb begin
		state_nxt = state;
		unique case (state)
			misc_pkg::REF_IDLE: begin
				// Forced when full, early when asked and something is owed
				if (full || (start_ref && notempty)) begin
					state_nxt = misc_pkg::REF_REQUEST;
				end
			end
			misc_pkg::REF_REQUEST: begin
				if (!notempty) begin
					state_nxt = misc_pkg::REF_IDLE;
				end
			end
			default: begin
				state_nxt = misc_pkg::REF_IDLE;
			end
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state <= misc_pkg::REF_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Drop the request as soon as the last owed refresh completes
	assign refreq = (state == misc_pkg::REF_REQUEST) & notempty;

	assign ref_count = rc;

endmodule

// File: interrupt/int_ctrl.sv
/* Five-source interrupt controller and read-bus merge; video and DSP are edge-triggered.
   A pending bit set and acknowledged in the same cycle toggles. */
`timescale 1ns/100ps

module int_ctrl (
	input  logic                     sys_clk,
	input  logic                     resetl,
	input  misc_pkg::data_word_t     din,
	input  logic                     int_wr,
	input  logic                     int2_wr,
	input  logic                     vint,
	input  logic                     gpuint,
	input  logic                     obint,
	input  logic                     dint,
	input  logic                     tint,
	input  logic                     int_rd,
	input  logic                     pit0_rd,
	input  logic                     pit1_rd,
	input  logic                     test_rd,
	input  misc_pkg::data_word_t     pit0_data,
	input  misc_pkg::data_word_t     pit1_data,
	input  misc_pkg::refresh_count_t ref_count,
	output logic                     intl,
	output logic                     ihandler,
	output misc_pkg::data_word_t     dr_out,
	output logic                     dr_oe,
	output logic                     dr_hi_oe
);

	localparam int unsigned INT_PAD_W = misc_pkg::DATA_W - misc_pkg::INT_SRC_N;
	localparam int unsigned RC_PAD_W  = misc_pkg::DATA_W - misc_pkg::REF_CNT_W;

	misc_pkg::int_mask_t ie;
	misc_pkg::int_mask_t ack_bits;
	misc_pkg::int_mask_t set_bits;
	misc_pkg::int_mask_t pend;

	// Two-flop samplers for the edge-triggered sources
	logic vi1;
	logic vi2;
	logic di1;
	logic di2;

	misc_pkg::data_word_t int_word;
	misc_pkg::data_word_t rc_word;

	// Enable mask from the low byte of an int write
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			ie <= '0;
		end else if (int_wr) begin
			ie <= din[misc_pkg::INT_SRC_N-1:0];
		end
	end

	// Acknowledge field only valid with the write strobe
	assign ack_bits = int_wr ?
		din[misc_pkg::INT_ACK_LSB +: misc_pkg::INT_SRC_N] : '0;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			vi1 <= 1'b0;
			vi2 <= 1'b0;
			di1 <= 1'b0;
			di2 <= 1'b0;
		end else begin
			vi1 <= vint;
			vi2 <= vi1;
			di1 <= dint;
			di2 <= di1;
		end
	end

	// Set terms, masked by the enables
	always_comb begin
		set_bits = '0;
		// Rising edge seen one flop after the first sample
		set_bits[misc_pkg::INT_VIDEO]  = vi1 & ~vi2 & ie[misc_pkg::INT_VIDEO];
		set_bits[misc_pkg::INT_GPU]    = gpuint & ie[misc_pkg::INT_GPU];
		set_bits[misc_pkg::INT_OBJECT] = obint & ie[misc_pkg::INT_OBJECT];
		set_bits[misc_pkg::INT_TIMER]  = tint & ie[misc_pkg::INT_TIMER];
		set_bits[misc_pkg::INT_DSP]    = di1 & ~di2 & ie[misc_pkg::INT_DSP];
	end

	// JK pending bits
	// j sets, k clears, both together toggles
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			pend <= '0;
		end else begin
			pend <= (set_bits & ~ack_bits) |
				(set_bits & ack_bits & ~pend) |
				(~set_bits & ~ack_bits & pend);
		end
	end

	// Active-low request while anything is pending
	assign intl = ~|pend;

	// Handler flag follows intl a cycle later and is cleared by int2 write
	// Clear only takes once nothing is pending
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			ihandler <= 1'b0;
		end else begin
			ihandler <= ~intl | (ihandler & ~int2_wr);
		end
	end

	// Read-back words, padded to bus width
	assign int_word = {{INT_PAD_W{1'b0}}, pend};
	assign rc_word  = {ref_count, {RC_PAD_W{1'b0}}};

	// Wired-OR of the selected sources, unselected ones give zero
	assign dr_out = (int_rd  ? int_word  : '0) |
		(pit0_rd ? pit0_data : '0) |
		(pit1_rd ? pit1_data : '0) |
		(test_rd ? rc_word   : '0);

	// Low bits driven for register reads, top nibble for the test read
	assign dr_oe    = int_rd | pit0_rd | pit1_rd;
	assign dr_hi_oe = test_rd;

endmodule

// File: verilog/misc_top.sv
/* Misc-control top level on a single sys_clk; write strobes come in already qualified.
   PRESCALE_BITS sets the refresh prescaler width. */
`timescale 1ns/100ps

module misc_top #(
	parameter int unsigned PRESCALE_BITS = 6
) (
	input  logic                    sys_clk,
	input  logic                    resetl,
	input  misc_pkg::data_word_t    din,
	input  logic                    pit0_wr,
	input  logic                    pit1_wr,
	input  logic                    int_wr,
	input  logic                    int2_wr,
	input  logic                    int_rd,
	input  logic                    pit0_rd,
	input  logic                    pit1_rd,
	input  logic                    test_rd,
	input  logic                    vint,
	input  logic                    gpuint,
	input  logic                    obint,
	input  logic                    dint,
	input  misc_pkg::refresh_rate_t refresh_rate,
	input  logic                    tcount,
	input  logic                    start_ref,
	input  logic                    refback,
	input  logic                    ack,
	input  logic                    mreq_in,
	output misc_pkg::data_word_t    dr_out,
	output logic                    dr_oe,
	output logic                    dr_hi_oe,
	output logic                    intl,
	output logic                    ihandler,
	output logic                    tint,
	output logic                    refreq
);

	// Read-back values gathered by the interrupt controller
	misc_pkg::data_word_t     pit0_data;
	misc_pkg::data_word_t     pit1_data;
	misc_pkg::refresh_count_t ref_count;

	// Timer, tint also feeds interrupt source 3
	pit_timer u_pit_timer (
		.sys_clk   (sys_clk),
		.resetl    (resetl),
		.din       (din),
		.pit0_wr   (pit0_wr),
		.pit1_wr   (pit1_wr),
		.tint      (tint),
		.pit0_data (pit0_data),
		.pit1_data (pit1_data)
	);

	refresh_ctrl #(
		.PRESCALE_BITS (PRESCALE_BITS)
	) u_refresh_ctrl (
		.sys_clk      (sys_clk),
		.resetl       (resetl),
		.refresh_rate (refresh_rate),
		.tcount       (tcount),
		.start_ref    (start_ref),
		.refback      (refback),
		.ack          (ack),
		.mreq_in      (mreq_in),
		.refreq       (refreq),
		.ref_count    (ref_count)
	);

	// Interrupts plus the shared read bus
	int_ctrl u_int_ctrl (
		.sys_clk   (sys_clk),
		.resetl    (resetl),
		.din       (din),
		.int_wr    (int_wr),
		.int2_wr   (int2_wr),
		.vint      (vint),
		.gpuint    (gpuint),
		.obint     (obint),
		.dint      (dint),
		.tint      (tint),
		.int_rd    (int_rd),
		.pit0_rd   (pit0_rd),
		.pit1_rd   (pit1_rd),
		.test_rd   (test_rd),
		.pit0_data (pit0_data),
		.pit1_data (pit1_data),
		.ref_count (ref_count),
		.intl      (intl),
		.ihandler  (ihandler),
		.dr_out    (dr_out),
		.dr_oe     (dr_oe),
		.dr_hi_oe  (dr_hi_oe)
	);

endmodule

// File: testbench/misc_tb.sv
/* Command-driven testbench for misc_top; reads testbench/misc_stimulus.txt from the project root.
   Every field of the stimulus file is hex; outputs are sampled on the falling edge. */
`timescale 1ns/100ps

module misc_tb;

	logic                    sys_clk;
	logic                    resetl;
	misc_pkg::data_word_t    din;
	logic                    pit0_wr;
	logic                    pit1_wr;
	logic                    int_wr;
	logic                    int2_wr;
	logic                    int_rd;
	logic                    pit0_rd;
	logic                    pit1_rd;
	logic                    test_rd;
	logic                    vint;
	logic                    gpuint;
	logic                    obint;
	logic                    dint;
	misc_pkg::refresh_rate_t refresh_rate;
	logic                    tcount;
	logic                    start_ref;
	logic                    refback;
	logic                    ack;
	logic                    mreq_in;
	misc_pkg::data_word_t    dr_out;
	logic                    dr_oe;
	logic                    dr_hi_oe;
	logic                    intl;
	logic                    ihandler;
	logic                    tint;
	logic                    refreq;

	int          mismatches;
	int          timeouts;
	logic [31:0] lfsr;

	misc_top #(
		.PRESCALE_BITS (6)
	) dut (
		.sys_clk (sys_clk), .resetl (resetl), .din (din),
		.pit0_wr (pit0_wr), .pit1_wr (pit1_wr), .int_wr (int_wr), .int2_wr (int2_wr),
		.int_rd (int_rd), .pit0_rd (pit0_rd), .pit1_rd (pit1_rd), .test_rd (test_rd),
		.vint (vint), .gpuint (gpuint), .obint (obint), .dint (dint),
		.refresh_rate (refresh_rate), .tcount (tcount), .start_ref (start_ref),
		.refback (refback), .ack (ack), .mreq_in (mreq_in),
		.dr_out (dr_out), .dr_oe (dr_oe), .dr_hi_oe (dr_hi_oe),
		.intl (intl), .ihandler (ihandler), .tint (tint), .refreq (refreq)
	);

	// 40 ns clock
	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			mismatches++;
			$display("mismatch %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// Taps 32,22,2,1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Select 0 pit0, 1 pit1, 2 int, 3 int2
	task automatic write_reg(input logic [31:0] sel, input logic [31:0] val);
		@(posedge sys_clk);
		din <= val[15:0];
		pit0_wr <= (sel == 32'd0);
		pit1_wr <= (sel == 32'd1);
		int_wr <= (sel == 32'd2);
		int2_wr <= (sel == 32'd3);
		@(posedge sys_clk);
		{pit0_wr, pit1_wr, int_wr, int2_wr} <= 4'b0000;
		din <= '0;
	endtask

	// Select 0 pit0, 1 pit1, 2 int, 3 refresh count
	task automatic read_reg(input string name, input logic [31:0] sel,
			input logic [31:0] expected);
		@(posedge sys_clk);
		pit0_rd <= (sel == 32'd0);
		pit1_rd <= (sel == 32'd1);
		int_rd <= (sel == 32'd2);
		test_rd <= (sel == 32'd3);
		@(negedge sys_clk);
		check(name, expected, {16'h0, dr_out});
		// Test read drives only the top nibble enable
		check(name, (sel == 32'd3) ? 32'd1 : 32'd2, {30'h0, dr_oe, dr_hi_oe});
		@(posedge sys_clk);
		{pit0_rd, pit1_rd, int_rd, test_rd} <= 4'b0000;
	endtask

	task automatic set_level(input logic [31:0] sel, input logic [31:0] val);
		@(posedge sys_clk);
		case (sel)
			32'd0: vint <= val[0];
			32'd1: gpuint <= val[0];
			32'd2: obint <= val[0];
			32'd3: dint <= val[0];
			32'd4: tcount <= val[0];
			32'd5: start_ref <= val[0];
			default: refresh_rate <= val[3:0];
		endcase
	endtask

	// 0 intl, 1 ihandler, 2 refreq, 3 tint
	function automatic logic get_out(input logic [31:0] sel);
		case (sel)
			32'd0: return intl;
			32'd1: return ihandler;
			32'd2: return refreq;
			default: return tint;
		endcase
	endfunction

	// Output level at the next falling edge
	task automatic expect_out(input string name, input logic [31:0] sel,
			input logic [31:0] val);
		@(negedge sys_clk);
		check(name, val, {31'h0, get_out(sel)});
	endtask

	task automatic wait_out(input string name, input logic [31:0] sel,
			input logic [31:0] val, input int max);
		int n;
		n = 0;
		@(negedge sys_clk);
		while (get_out(sel) !== val[0] && n < max) begin
			@(negedge sys_clk);
			n++;
		end
		if (get_out(sel) !== val[0]) begin
			timeouts++;
			$display("timeout %s: output %0d did not reach %0b in %0d cycles",
				name, sel, val[0], max);
		end
	endtask

	// Cycles high within the window
	task automatic count_high(input string name, input logic [31:0] sel, input int n,
			input int expected);
		int cnt;
		cnt = 0;
		repeat (n) begin
			@(negedge sys_clk);
			if (get_out(sel)) cnt++;
		end
		check(name, expected, cnt);
	endtask

	task automatic complete_refresh();
		@(posedge sys_clk);
		{refback, ack, mreq_in} <= 3'b111;
		@(posedge sys_clk);
		{refback, ack, mreq_in} <= 3'b000;
	endtask

	// Cycles between two successive steps of the owed count
	task automatic measure_step(input string name, input int expected, input int max);
		int n;
		logic [3:0] v0;
		@(posedge sys_clk);
		test_rd <= 1'b1;
		@(negedge sys_clk);
		v0 = dr_out[15:12];
		n = 0;
		while (dr_out[15:12] == v0 && n < max) begin
			@(negedge sys_clk);
			n++;
		end
		if (n >= max) begin
			timeouts++;
			$display("timeout %s: refresh count never changed", name);
		end else begin
			v0 = dr_out[15:12];
			n = 0;
			do begin
				@(negedge sys_clk);
				n++;
			end while (dr_out[15:12] == v0 && n < max);
			check(name, expected, n);
			check(name, {28'h0, v0} + 32'd1, {28'h0, dr_out[15:12]});
		end
		@(posedge sys_clk);
		test_rd <= 1'b0;
	endtask

	// Random small P and T over a window of three full periods
	task automatic random_timer(input string name, input int rounds);
		logic [31:0] p;
		logic [31:0] t;
		int period;
		int expected;
		for (int i = 0; i < rounds; i++) begin
			rand_bits(2, p);
			rand_bits(2, t);
			period = (int'(p) + 1) * (int'(t) + 1);
			expected = (p == 32'd0) ? 0 : (3 * period) / period;
			write_reg(32'd0, p);
			write_reg(32'd1, t);
			count_high($sformatf("%s P=%0d T=%0d", name, p, t), 32'd3,
				3 * period, expected);
		end
	endtask

	initial begin
		int fd;
		int lineno;
		string line;
		string cmd;
		string name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		mismatches = 0;
		timeouts = 0;
		lfsr = 32'hcebcaec8;
		resetl = 1'b0;
		din = '0;
		{pit0_wr, pit1_wr, int_wr, int2_wr} = 4'b0000;
		{int_rd, pit0_rd, pit1_rd, test_rd} = 4'b0000;
		{vint, gpuint, obint, dint} = 4'b0000;
		refresh_rate = '0;
		{tcount, start_ref, refback, ack, mreq_in} = 5'b00000;
		repeat (16) @(posedge sys_clk);
		resetl <= 1'b1;
		@(posedge sys_clk);
		lineno = 0;
		fd = $fopen("testbench/misc_stimulus.txt", "r");
		if (fd == 0) begin
			timeouts++;
			$display("could not open the stimulus file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				lineno++;
				if (line.len() < 2 || line.substr(0, 0) == "#") continue;
				a = '0;
				b = '0;
				c = '0;
				void'($sscanf(line, "%s %h %h %h", cmd, a, b, c));
				name = $sformatf("%s line %0d", cmd, lineno);
				case (cmd)
					"W": write_reg(a, b);
					"R": read_reg(name, a, b);
					"L": set_level(a, b);
					"C": repeat (int'(a)) @(posedge sys_clk);
					"T": count_high(name, a, int'(b), int'(c));
					"U": wait_out(name, a, b, int'(c));
					"O": expect_out(name, a, b);
					"I": measure_step(name, int'(a), int'(b));
					"K": complete_refresh();
					"X": random_timer(name, int'(a));
					default: begin
						timeouts++;
						$display("unknown command on stimulus line %0d", lineno);
					end
				endcase
			end
			$fclose(fd);
		end
		$display("errors: %0d mismatches, %0d other failures", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: testbench/misc_stimulus.txt
# cmd a b c, all hex. W reg val | R reg exp | L input val | C cycles | T out cycles count
# U out val timeout | O out val | I interval timeout | K | X rounds
O 0 1
O 1 0
O 2 0
O 3 0
R 0 0000
R 1 0000
R 2 0000
R 3 0000
W 0 0003
W 1 0002
T 3 0078 000A
W 0 0001
W 1 0000
T 3 0028 0014
W 0 0000
T 3 0032 0000
X 6
W 0 0001
W 1 0001
W 2 0008
U 0 0 0014
C 2
O 1 1
R 2 0008
W 0 0000
C 1
R 0 0000
R 1 0000
W 2 0800
O 0 1
O 1 1
W 3 0000
O 1 0
L 1 1
C 4
O 0 1
R 2 0000
W 2 0002
C 2
O 0 0
R 2 0002
L 1 0
W 2 0200
O 0 1
W 3 0000
O 1 0
W 2 0001
L 0 1
C 6
O 0 0
R 2 0001
W 2 0101
C 6
O 0 1
L 0 0
C 3
L 0 1
C 4
R 2 0001
W 2 0100
L 0 0
W 2 0010
L 3 1
C 6
R 2 0010
W 2 1010
C 6
R 2 0000
L 3 0
W 2 0000
W 3 0000
O 1 0
L 6 3
L 4 1
I 4 0028
U 2 1 0050
R 3 8000
L 4 0
L 6 0
K
K
K
K
K
K
K
R 3 1000
O 2 1
K
O 2 0
R 3 0000
C 12C
L 4 1
L 6 2
L 6 0
L 4 0
C 3
O 2 0
R 3 1000
L 5 1
U 2 1 000A
L 5 0
K
O 2 0
R 3 0000
L 4 1
C 28
R 3 0000
O 2 0
L 4 0

// File: tb.f
common/misc_pkg.sv
timer/pit_timer.sv
refresh/refresh_ctrl.sv
interrupt/int_ctrl.sv
verilog/misc_top.sv
testbench/misc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the misc_top testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module misc_tb -f tb.f -o misc_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/misc_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation run returned an error, see sim.log"
	exit 1
fi

if grep -q "Simulation passed" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL, see sim.log"
exit 1
